// File: common/memCtrlPkg.sv
package memCtrlPkg;

    localparam int NUM_TFS = 4;
    localparam int ID_LEN = 2;
    localparam int ADDR_LEN = 32;
    localparam int DATA_W = 32;
    localparam int LINE_BEATS = 4;
    localparam int CACHE_ADDR_W = 10;

    // AXI encodings used by the address channels
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    typedef logic [ID_LEN-1:0] slotIdT;
    typedef logic [CACHE_ADDR_W-1:0] cacheAddrT;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_FILL,
        CMD_WRITEBACK,
        CMD_LOAD
    } memCmd;

    // for CMD_LOAD, cacheAddr carries the client tag
    typedef struct packed {
        memCmd cmd;
        logic [ADDR_LEN-1:0] extAddr;
        cacheAddrT cacheAddr;
    } memReq;

    typedef struct packed {
        logic stall;
        logic ldValid;
        cacheAddrT ldTag;
        logic [DATA_W-1:0] ldData;
    } memStat;

    typedef struct packed {
        logic ce;
        logic we;
        cacheAddrT addr;
        logic [DATA_W-1:0] data;
    } cacheReq;

    typedef struct packed {
        logic valid;
        memCmd cmd;
        logic [ADDR_LEN-1:0] extAddr;
        cacheAddrT cacheAddr;
        logic needRead;
        logic needAw;
        logic needCacheRd;
        logic [$clog2(LINE_BEATS):0] beatCount;
    } slotState;

endpackage

// File: transferTable/transferTable.sv
`timescale 1ns/1ps

module transferTable (
    input  logic clk,
    input  logic rst,
    input  memCtrlPkg::memReq req,
    input  logic arTaken,
    input  memCtrlPkg::slotIdT arIdx,
    input  logic awTaken,
    input  memCtrlPkg::slotIdT awIdx,
    input  logic rdTaken,
    input  memCtrlPkg::slotIdT rdIdx,
    input  logic beatValid,
    input  memCtrlPkg::slotIdT beatId,
    input  logic [memCtrlPkg::DATA_W-1:0] beatData,
    input  logic writeAck,
    input  memCtrlPkg::slotIdT ackId,
    input  logic bvalid,
    input  memCtrlPkg::slotIdT bid,
    output memCtrlPkg::slotState [memCtrlPkg::NUM_TFS-1:0] slots,
    output memCtrlPkg::memStat stat
);

    memCtrlPkg::slotIdT freeIdx;
    logic freeFound;
    logic accept;
    logic [memCtrlPkg::NUM_TFS-1:0] freeSlot;
    logic ldPulse;
    memCtrlPkg::cacheAddrT ldTagReg;
    logic [memCtrlPkg::DATA_W-1:0] ldDataReg;

    // lowest empty slot takes the next request
    always_comb begin
        freeIdx = '0;
        freeFound = 1'b0;
        for (int i = 0; i < memCtrlPkg::NUM_TFS; i++) begin
            if (!freeFound && !slots[i].valid) begin
                freeIdx = memCtrlPkg::slotIdT'(i);
                freeFound = 1'b1;
            end
        end
    end

    assign accept = freeFound && (req.cmd != memCtrlPkg::CMD_NONE);

    // fill ends on its last ack, write-back on B, load on its R beat
    always_comb begin
        for (int i = 0; i < memCtrlPkg::NUM_TFS; i++) begin
            freeSlot[i] = (writeAck && int'(ackId) == i
                    && int'(slots[i].beatCount) == memCtrlPkg::LINE_BEATS - 1)
                || (bvalid && int'(bid) == i)
                || (beatValid && int'(beatId) == i && slots[i].cmd == memCtrlPkg::CMD_LOAD);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slots <= '0;
            ldPulse <= 1'b0;
        end else begin
            ldPulse <= beatValid && (slots[beatId].cmd == memCtrlPkg::CMD_LOAD);
            for (int i = 0; i < memCtrlPkg::NUM_TFS; i++) begin
                if (accept && int'(freeIdx) == i) begin
                    slots[i].valid <= 1'b1;
                    slots[i].cmd <= req.cmd;
                    slots[i].extAddr <= req.extAddr;
                    slots[i].cacheAddr <= req.cacheAddr;
                    slots[i].needRead <= (req.cmd != memCtrlPkg::CMD_WRITEBACK);
                    slots[i].needAw <= (req.cmd == memCtrlPkg::CMD_WRITEBACK);
                    slots[i].needCacheRd <= (req.cmd == memCtrlPkg::CMD_WRITEBACK);
                    slots[i].beatCount <= '0;
                end
                if (arTaken && int'(arIdx) == i) begin
                    slots[i].needRead <= 1'b0;
                end
                if (awTaken && int'(awIdx) == i) begin
                    slots[i].needAw <= 1'b0;
                end
                if (rdTaken && int'(rdIdx) == i) begin
                    slots[i].needCacheRd <= 1'b0;
                end
                if (writeAck && int'(ackId) == i) begin
                    slots[i].beatCount <= slots[i].beatCount + 1'b1;
                end
                if (freeSlot[i]) begin
                    slots[i].valid <= 1'b0;
                    slots[i].cmd <= memCtrlPkg::CMD_NONE;
                end
            end
        end
    end

    // load result, qualified by ldPulse
    always_ff @(posedge clk) begin
        if (beatValid) begin
            ldTagReg <= slots[beatId].cacheAddr;
            ldDataReg <= beatData;
        end
    end

    assign stat = '{stall: !freeFound, ldValid: ldPulse, ldTag: ldTagReg, ldData: ldDataReg};

    ackNamesLiveFill: assert property (@(posedge clk) disable iff (rst)
        writeAck |-> slots[ackId].valid && slots[ackId].cmd == memCtrlPkg::CMD_FILL);

    bNamesLiveWriteback: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> slots[bid].valid && slots[bid].cmd == memCtrlPkg::CMD_WRITEBACK);

endmodule

// File: transferTable/axiRequestIssue.sv
`timescale 1ns/1ps

module axiRequestIssue (
    input  logic clk,
    input  logic rst,
    input  memCtrlPkg::slotState [memCtrlPkg::NUM_TFS-1:0] slots,
    input  logic arready,
    input  logic awready,
    input  logic rdReady,
    output logic arTaken,
    output memCtrlPkg::slotIdT arIdx,
    output logic awTaken,
    output memCtrlPkg::slotIdT awIdx,
    output logic rdTaken,
    output memCtrlPkg::slotIdT rdIdx,
    output memCtrlPkg::slotIdT arid,
    output logic [memCtrlPkg::ADDR_LEN-1:0] araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic arvalid,
    output memCtrlPkg::slotIdT awid,
    output logic [memCtrlPkg::ADDR_LEN-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic awvalid,
    output logic rdValid,
    output memCtrlPkg::slotIdT rdId,
    output memCtrlPkg::cacheAddrT rdAddr
);

    memCtrlPkg::slotIdT arSel;
    logic arFound;
    memCtrlPkg::slotIdT wrSel;
    logic wrFound;
    logic wrHeld;

    function automatic logic [7:0] burstLen(memCtrlPkg::memCmd cmd);
        return (cmd == memCtrlPkg::CMD_LOAD) ? 8'd0 : 8'(memCtrlPkg::LINE_BEATS - 1);
    endfunction

    always_comb begin
        arSel = '0;
        arFound = 1'b0;
        for (int i = 0; i < memCtrlPkg::NUM_TFS; i++) begin
            if (!arFound && slots[i].valid && slots[i].needRead) begin
                arSel = memCtrlPkg::slotIdT'(i);
                arFound = 1'b1;
            end
        end
    end

    // a write-back taken on only one side keeps the choice,
    // so cache reads and AW stay in the same order
    always_comb begin
        wrSel = '0;
        wrFound = 1'b0;
        wrHeld = 1'b0;
        for (int i = 0; i < memCtrlPkg::NUM_TFS; i++) begin
            if (slots[i].valid && (slots[i].needAw || slots[i].needCacheRd)) begin
                if (!wrHeld && (!wrFound || (slots[i].needAw != slots[i].needCacheRd))) begin
                    wrSel = memCtrlPkg::slotIdT'(i);
                    wrFound = 1'b1;
                    wrHeld = slots[i].needAw != slots[i].needCacheRd;
                end
            end
        end
    end

    assign arvalid = arFound;
    assign arid = arSel;
    assign araddr = arFound ? slots[arSel].extAddr : '0;
    assign arlen = arFound ? burstLen(slots[arSel].cmd) : 8'd0;
    assign arsize = memCtrlPkg::SIZE_WORD;
    assign arburst = memCtrlPkg::BURST_INCR;

    assign awvalid = wrFound && slots[wrSel].needAw;
    assign awid = wrSel;
    assign awaddr = wrFound ? slots[wrSel].extAddr : '0;
    assign awlen = wrFound ? burstLen(slots[wrSel].cmd) : 8'd0;
    assign awsize = memCtrlPkg::SIZE_WORD;
    assign awburst = memCtrlPkg::BURST_INCR;

    assign rdValid = wrFound && slots[wrSel].needCacheRd;
    assign rdId = wrSel;
    assign rdAddr = slots[wrSel].cacheAddr;

    assign arTaken = arvalid && arready;
    assign arIdx = arSel;
    assign awTaken = awvalid && awready;
    assign awIdx = wrSel;
    assign rdTaken = rdValid && rdReady;
    assign rdIdx = wrSel;

    // half-taken write-back must be finished before another slot is picked
    halfTakenHoldsSlot: assert property (@(posedge clk) disable iff (rst)
        ((awTaken && !rdTaken && slots[wrSel].needCacheRd)
            || (rdTaken && !awTaken && slots[wrSel].needAw))
        |=> wrFound && wrSel == $past(wrSel));

endmodule

// File: cacheIf/cacheFillWriter.sv
`timescale 1ns/1ps

module cacheFillWriter (
    input  logic clk,
    input  logic rst,
    input  memCtrlPkg::slotState [memCtrlPkg::NUM_TFS-1:0] slots,
    input  memCtrlPkg::slotIdT rid,
    input  logic [memCtrlPkg::DATA_W-1:0] rdata,
    input  logic rvalid,
    input  memCtrlPkg::cacheReq rdCache,
    output logic rready,
    output logic beatValid,
    output memCtrlPkg::slotIdT beatId,
    output logic [memCtrlPkg::DATA_W-1:0] beatData,
    output logic writeAck,
    output memCtrlPkg::slotIdT ackId,
    output logic rdGrant,
    output memCtrlPkg::cacheReq cacheOut
);

    logic holdValid;
    memCtrlPkg::slotIdT holdId;
    memCtrlPkg::cacheAddrT holdAddr;
    logic [memCtrlPkg::DATA_W-1:0] holdData;
    logic writeNow;
    logic isLoad;
    logic takeFill;
    memCtrlPkg::cacheAddrT beatOffset;

    // reader always wins the port
    assign rdGrant = rdCache.ce;
    assign writeNow = holdValid && !rdCache.ce;

    assign isLoad = slots[rid].cmd == memCtrlPkg::CMD_LOAD;
    assign rready = rvalid && (isLoad || !holdValid || writeNow);
    assign beatValid = rvalid && rready;
    assign beatId = rid;
    assign beatData = rdata;
    assign takeFill = beatValid && !isLoad;

    // held beat of the same slot is acked this cycle, so count it too
    assign beatOffset = memCtrlPkg::cacheAddrT'(slots[rid].beatCount)
        + memCtrlPkg::cacheAddrT'(holdValid && holdId == rid);

    assign writeAck = writeNow;
    assign ackId = holdId;

    always_comb begin
        cacheOut = '0;
        if (rdCache.ce) begin
            cacheOut = rdCache;
        end else if (writeNow) begin
            cacheOut.ce = 1'b1;
            cacheOut.we = 1'b1;
            cacheOut.addr = holdAddr;
            cacheOut.data = holdData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            holdValid <= 1'b0;
        end else if (takeFill) begin
            holdValid <= 1'b1;
        end else if (writeNow) begin
            holdValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (takeFill) begin
            holdId <= rid;
            holdAddr <= slots[rid].cacheAddr + beatOffset;
            holdData <= rdata;
        end
    end

endmodule

// File: cacheIf/cacheLineReader.sv
`timescale 1ns/1ps

module cacheLineReader (
    input  logic clk,
    input  logic rst,
    input  logic rdValid,
    input  memCtrlPkg::cacheAddrT rdAddr,
    input  logic rdGrant,
    input  logic [memCtrlPkg::DATA_W-1:0] cacheRdata,
    input  logic wready,
    output logic rdReady,
    output memCtrlPkg::cacheReq rdCache,
    output logic [memCtrlPkg::DATA_W-1:0] wdata,
    output logic [memCtrlPkg::DATA_W/8-1:0] wstrb,
    output logic wlast,
    output logic wvalid
);

    typedef enum logic {
        RD_IDLE,
        RD_BUSY
    } readerState;

    readerState state;
    memCtrlPkg::cacheAddrT baseAddr;
    logic [$clog2(memCtrlPkg::LINE_BEATS)-1:0] readCnt;
    logic lastRead;
    logic readIssued;
    logic outFree;
    logic pendValid;
    logic pendLast;
    logic skidValid;
    logic skidLast;
    logic [memCtrlPkg::DATA_W-1:0] skidData;

    assign rdReady = (state == RD_IDLE) && rdValid;
    assign outFree = !wvalid || wready;
    assign lastRead = int'(readCnt) == memCtrlPkg::LINE_BEATS - 1;

    // only read when the returning word is sure to find a place
    assign rdCache.ce = (state == RD_BUSY) && !skidValid && outFree;
    assign rdCache.we = 1'b0;
    assign rdCache.addr = baseAddr + memCtrlPkg::cacheAddrT'(readCnt);
    assign rdCache.data = '0;
    assign readIssued = rdCache.ce && rdGrant;

    assign wstrb = '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
            readCnt <= '0;
            pendValid <= 1'b0;
            skidValid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rdValid) begin
                        state <= RD_BUSY;
                        readCnt <= '0;
                    end
                end
                RD_BUSY: begin
                    if (readIssued) begin
                        readCnt <= readCnt + 1'b1;
                        if (lastRead) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
            pendValid <= readIssued;
            if (outFree) begin
                wvalid <= skidValid || pendValid;
                skidValid <= skidValid && pendValid;
            end else if (pendValid) begin
                skidValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdReady) begin
            baseAddr <= rdAddr;
        end
        if (readIssued) begin
            pendLast <= lastRead;
        end
        // skid entry is older than the word arriving now
        if (outFree) begin
            if (skidValid) begin
                wdata <= skidData;
                wlast <= skidLast;
            end else if (pendValid) begin
                wdata <= cacheRdata;
                wlast <= pendLast;
            end
        end
        if (pendValid && (skidValid || !outFree)) begin
            skidData <= cacheRdata;
            skidLast <= pendLast;
        end
    end

    wBeatHeldUnderStall: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast));

endmodule

// File: hdl/memController.sv
`timescale 1ns/1ps

module memController (
    input  logic clk,
    input  logic rst,
    input  memCtrlPkg::memReq req,
    output memCtrlPkg::memStat stat,

    output memCtrlPkg::cacheReq cacheOut,
    input  logic [memCtrlPkg::DATA_W-1:0] cacheRdata,

    output memCtrlPkg::slotIdT arid,
    output logic [memCtrlPkg::ADDR_LEN-1:0] araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic arvalid,
    input  logic arready,

    input  memCtrlPkg::slotIdT rid,
    input  logic [memCtrlPkg::DATA_W-1:0] rdata,
    input  logic rlast,
    input  logic rvalid,
    output logic rready,

    output memCtrlPkg::slotIdT awid,
    output logic [memCtrlPkg::ADDR_LEN-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic awvalid,
    input  logic awready,

    output logic [memCtrlPkg::DATA_W-1:0] wdata,
    output logic [memCtrlPkg::DATA_W/8-1:0] wstrb,
    output logic wlast,
    output logic wvalid,
    input  logic wready,

    input  memCtrlPkg::slotIdT bid,
    input  logic bvalid,
    output logic bready
);

    memCtrlPkg::slotState [memCtrlPkg::NUM_TFS-1:0] slots;

    // handshake strobes back into the table
    logic arTaken;
    logic awTaken;
    logic rdTaken;
    memCtrlPkg::slotIdT arIdx;
    memCtrlPkg::slotIdT awIdx;
    memCtrlPkg::slotIdT rdIdx;

    // line reader request
    logic rdValid;
    logic rdReady;
    memCtrlPkg::cacheAddrT rdAddr;

    // accepted R beats and SRAM write acks
    logic beatValid;
    memCtrlPkg::slotIdT beatId;
    logic [memCtrlPkg::DATA_W-1:0] beatData;
    logic writeAck;
    memCtrlPkg::slotIdT ackId;

    // reader side of the shared SRAM port
    memCtrlPkg::cacheReq rdCache;
    logic rdGrant;

    // write responses are never back-pressured
    assign bready = 1'b1;

    transferTable u_transferTable (.*);

    axiRequestIssue u_axiRequestIssue (.*, .rdId());

    cacheFillWriter u_cacheFillWriter (.*);

    cacheLineReader u_cacheLineReader (.*);

endmodule

// File: verification/axiMemModel.sv
`timescale 1ns/1ps

module axiMemModel (
    input  logic clk,
    input  logic rst,
    input  logic arStop,
    input  memCtrlPkg::slotIdT arid,
    input  logic [memCtrlPkg::ADDR_LEN-1:0] araddr,
    input  logic [7:0] arlen,
    input  logic arvalid,
    output logic arready,
    output memCtrlPkg::slotIdT rid,
    output logic [memCtrlPkg::DATA_W-1:0] rdata,
    output logic rlast,
    output logic rvalid,
    input  logic rready,
    input  memCtrlPkg::slotIdT awid,
    input  logic [memCtrlPkg::ADDR_LEN-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [memCtrlPkg::DATA_W-1:0] wdata,
    input  logic wlast,
    input  logic wvalid,
    output logic wready,
    output memCtrlPkg::slotIdT bid,
    output logic bvalid,
    input  logic bready,
    input  memCtrlPkg::cacheReq cacheOut,
    output logic [memCtrlPkg::DATA_W-1:0] cacheRdata
);

    localparam int WORDS = 1 << memCtrlPkg::CACHE_ADDR_W;

    logic [memCtrlPkg::DATA_W-1:0] mem [0:WORDS-1];
    logic [memCtrlPkg::DATA_W-1:0] sram [0:WORDS-1];

    memCtrlPkg::slotIdT arIdQ [$];
    logic [memCtrlPkg::ADDR_LEN-1:0] arAddrQ [$];
    logic [7:0] arLenQ [$];
    int rBeat;

    memCtrlPkg::slotIdT awIdQ [$];
    logic [memCtrlPkg::ADDR_LEN-1:0] awAddrQ [$];
    memCtrlPkg::slotIdT bIdQ [$];
    int awGap;
    int wBeat;

    function automatic memCtrlPkg::cacheAddrT wordIdx(logic [memCtrlPkg::ADDR_LEN-1:0] addr);
        return memCtrlPkg::cacheAddrT'(addr >> 2);
    endfunction

    // random contents for both memories
    task automatic fillRandom();
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = $urandom;
            sram[i] = $urandom;
        end
    endtask

    initial begin
        arready = 1'b0;
        rid = '0;
        rdata = '0;
        rlast = 1'b0;
        rvalid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bid = '0;
        bvalid = 1'b0;
        cacheRdata = '0;
    end

    // read bursts served in AR order, with random gaps between beats
    always @(posedge clk) begin : rChannel
        int nextBeat;
        logic present;
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rBeat <= 0;
            arIdQ.delete();
            arAddrQ.delete();
            arLenQ.delete();
        end else begin
            arready <= !arStop && ($urandom % 4 != 0);
            if (arvalid && arready) begin
                arIdQ.push_back(arid);
                arAddrQ.push_back(araddr);
                arLenQ.push_back(arlen);
            end
            present = !rvalid;
            nextBeat = rBeat;
            if (rvalid && rready) begin
                present = 1'b1;
                if (rlast) begin
                    void'(arIdQ.pop_front());
                    void'(arAddrQ.pop_front());
                    void'(arLenQ.pop_front());
                    nextBeat = 0;
                end else begin
                    nextBeat = rBeat + 1;
                end
            end
            rBeat <= nextBeat;
            if (present) begin
                if (arIdQ.size() > 0 && ($urandom % 3 != 0)) begin
                    rvalid <= 1'b1;
                    rid <= arIdQ[0];
                    rdata <= mem[wordIdx(arAddrQ[0]) + memCtrlPkg::cacheAddrT'(nextBeat)];
                    rlast <= nextBeat == int'(arLenQ[0]);
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

    // awready idles high and drops for a few cycles after each address
    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            awGap <= 0;
            wready <= 1'b0;
            wBeat <= 0;
            bvalid <= 1'b0;
            awIdQ.delete();
            awAddrQ.delete();
            bIdQ.delete();
        end else begin
            if (awvalid && awready) begin
                awIdQ.push_back(awid);
                awAddrQ.push_back(awaddr);
                awready <= 1'b0;
                awGap <= $urandom % 4;
            end else if (awGap != 0) begin
                awGap <= awGap - 1;
            end else begin
                awready <= 1'b1;
            end
            if (wvalid && wready) begin
                mem[wordIdx(awAddrQ[0]) + memCtrlPkg::cacheAddrT'(wBeat)] <= wdata;
                wBeat <= wlast ? 0 : wBeat + 1;
                if (wlast) begin
                    bIdQ.push_back(awIdQ[0]);
                    void'(awIdQ.pop_front());
                    void'(awAddrQ.pop_front());
                end
            end
            // W only once its address has arrived
            wready <= (awIdQ.size() > 0) && ($urandom % 3 != 0);
            if (!bvalid || bready) begin
                if (bIdQ.size() > 0) begin
                    bvalid <= 1'b1;
                    bid <= bIdQ.pop_front();
                end else begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

    // cache SRAM, read data one cycle after the read
    always @(posedge clk) begin
        if (cacheOut.ce) begin
            if (cacheOut.we) begin
                sram[cacheOut.addr] <= cacheOut.data;
            end else begin
                cacheRdata <= sram[cacheOut.addr];
            end
        end
    end

endmodule

// File: verification/memControllerTb.sv
`timescale 1ns/1ps

module memControllerTb;

    localparam int NUM_TESTS = 6;
    localparam int CLK_PERIOD = 8;

    logic clk;
    logic rst;
    logic arStop;
    memCtrlPkg::memReq req;
    memCtrlPkg::memStat stat;
    memCtrlPkg::cacheReq cacheOut;
    logic [memCtrlPkg::DATA_W-1:0] cacheRdata;
    memCtrlPkg::slotIdT arid;
    logic [memCtrlPkg::ADDR_LEN-1:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic arvalid;
    logic arready;
    memCtrlPkg::slotIdT rid;
    logic [memCtrlPkg::DATA_W-1:0] rdata;
    logic rlast;
    logic rvalid;
    logic rready;
    memCtrlPkg::slotIdT awid;
    logic [memCtrlPkg::ADDR_LEN-1:0] awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic awvalid;
    logic awready;
    logic [memCtrlPkg::DATA_W-1:0] wdata;
    logic [memCtrlPkg::DATA_W/8-1:0] wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    memCtrlPkg::slotIdT bid;
    logic bvalid;
    logic bready;

    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int accepted = 0;
    int fillWrites = 0;
    int bCount = 0;
    int ldCount = 0;
    int wBeat = 0;
    memCtrlPkg::cacheAddrT expTag [$];
    logic [memCtrlPkg::DATA_W-1:0] expData [$];
    memCtrlPkg::slotIdT awIdSeen [$];
    // expected AR burst length, by word address of the request
    logic [7:0] arLenByWord [0:(1 << memCtrlPkg::CACHE_ADDR_W)-1];

    memController u_memController (.*);

    axiMemModel u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic endTest(string name, int startErrs);
        testsRun++;
        if (errorCount == startErrs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errorCount - startErrs);
            testsFailed++;
        end
    endtask

    function automatic int completions();
        return fillWrites / memCtrlPkg::LINE_BEATS + bCount + ldCount;
    endfunction

    task automatic driveReq(memCtrlPkg::memCmd cmd, logic [31:0] ext,
            memCtrlPkg::cacheAddrT cache);
        // one beat for a load, a whole line otherwise
        arLenByWord[memCtrlPkg::cacheAddrT'(ext >> 2)] =
            (cmd == memCtrlPkg::CMD_LOAD) ? 8'd0 : 8'd3;
        @(posedge clk);
        req.cmd <= cmd;
        req.extAddr <= ext;
        req.cacheAddr <= cache;
    endtask

    // request is taken on the first edge with stall low
    task automatic waitAccept();
        @(negedge clk);
        while (stat.stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        req.cmd <= memCtrlPkg::CMD_NONE;
        accepted++;
    endtask

    task automatic issueReq(memCtrlPkg::memCmd cmd, logic [31:0] ext,
            memCtrlPkg::cacheAddrT cache);
        driveReq(cmd, ext, cache);
        waitAccept();
    endtask

    task automatic expectLoad(logic [31:0] ext, memCtrlPkg::cacheAddrT tag);
        expTag.push_back(tag);
        expData.push_back(u_mem.mem[memCtrlPkg::cacheAddrT'(ext >> 2)]);
    endtask

    task automatic waitCompletions();
        while (completions() < accepted) begin
            @(negedge clk);
        end
        // let the last SRAM or memory write land
        repeat (4) @(posedge clk);
    endtask

    task automatic checkFillLine(logic [31:0] ext, memCtrlPkg::cacheAddrT cache);
        memCtrlPkg::cacheAddrT memIdx;
        memCtrlPkg::cacheAddrT sramIdx;
        for (int i = 0; i < memCtrlPkg::LINE_BEATS; i++) begin
            memIdx = memCtrlPkg::cacheAddrT'(ext >> 2) + memCtrlPkg::cacheAddrT'(i);
            sramIdx = cache + memCtrlPkg::cacheAddrT'(i);
            checkValue($sformatf("sram[%0d]", sramIdx), u_mem.mem[memIdx], u_mem.sram[sramIdx]);
        end
    endtask

    task automatic checkWbLine(logic [31:0] ext, memCtrlPkg::cacheAddrT cache);
        memCtrlPkg::cacheAddrT memIdx;
        memCtrlPkg::cacheAddrT sramIdx;
        for (int i = 0; i < memCtrlPkg::LINE_BEATS; i++) begin
            memIdx = memCtrlPkg::cacheAddrT'(ext >> 2) + memCtrlPkg::cacheAddrT'(i);
            sramIdx = cache + memCtrlPkg::cacheAddrT'(i);
            checkValue($sformatf("mem[%0d]", memIdx), u_mem.sram[sramIdx], u_mem.mem[memIdx]);
        end
    endtask

    // loads may return out of request order, so match by tag
    task automatic matchLoad();
        int hit;
        hit = -1;
        foreach (expTag[i]) begin
            if (hit < 0 && expTag[i] == stat.ldTag) begin
                hit = i;
            end
        end
        assert (hit >= 0) else begin
            $display("ldValid at %0t returned tag %h that no load is waiting for", $time,
                stat.ldTag);
            errorCount++;
        end
        if (hit >= 0) begin
            checkValue("stat.ldData", expData[hit], stat.ldData);
            expTag.delete(hit);
            expData.delete(hit);
        end
        ldCount++;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (cacheOut.ce && cacheOut.we) begin
                fillWrites++;
            end
            if (arvalid) begin
                checkValue("arlen", arLenByWord[memCtrlPkg::cacheAddrT'(araddr >> 2)], arlen);
                checkValue("arsize", 3'd2, arsize);
                checkValue("arburst", 2'b01, arburst);
            end
            if (awvalid) begin
                checkValue("awlen", memCtrlPkg::LINE_BEATS - 1, awlen);
                checkValue("awsize", 3'd2, awsize);
                checkValue("awburst", 2'b01, awburst);
            end
            if (awvalid && awready) begin
                awIdSeen.push_back(awid);
            end
            if (bvalid && bready) begin
                assert (awIdSeen.size() > 0) else begin
                    $display("write response at %0t with no write address outstanding", $time);
                    errorCount++;
                end
                if (awIdSeen.size() > 0) begin
                    checkValue("bid", awIdSeen.pop_front(), bid);
                end
                bCount++;
            end
            if (stat.ldValid) begin
                matchLoad();
            end
            if (wvalid) begin
                checkValue("wstrb", 4'hf, wstrb);
            end
            if (wvalid && wready) begin
                checkValue("wlast", wBeat == memCtrlPkg::LINE_BEATS - 1, wlast);
                wBeat = (wBeat + 1) % memCtrlPkg::LINE_BEATS;
            end
        end
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("timeout after %0d cycles, a transfer never completed", NUM_TESTS * 2000);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int startErrs;
        void'($urandom(32'hbe98));
        rst = 1'b1;
        arStop = 1'b0;
        req = '0;
        u_mem.fillRandom();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        startErrs = errorCount;
        @(negedge clk);
        checkValue("arvalid", 0, arvalid);
        checkValue("awvalid", 0, awvalid);
        checkValue("wvalid", 0, wvalid);
        checkValue("rready", 0, rready);
        checkValue("stat.ldValid", 0, stat.ldValid);
        checkValue("cacheOut.ce", 0, cacheOut.ce);
        checkValue("stat.stall", 0, stat.stall);
        endTest("reset", startErrs);

        startErrs = errorCount;
        issueReq(memCtrlPkg::CMD_FILL, 32'h100, 10'h040);
        waitCompletions();
        checkFillLine(32'h100, 10'h040);
        endTest("fill", startErrs);

        startErrs = errorCount;
        issueReq(memCtrlPkg::CMD_WRITEBACK, 32'h200, 10'h080);
        waitCompletions();
        checkWbLine(32'h200, 10'h080);
        endTest("writeback", startErrs);

        startErrs = errorCount;
        expectLoad(32'h304, 10'h3a5);
        issueReq(memCtrlPkg::CMD_LOAD, 32'h304, 10'h3a5);
        expectLoad(32'h318, 10'h011);
        issueReq(memCtrlPkg::CMD_LOAD, 32'h318, 10'h011);
        waitCompletions();
        checkValue("pending loads", 0, expTag.size());
        endTest("load", startErrs);

        // four loads park in the table while AR is blocked
        startErrs = errorCount;
        @(posedge clk);
        arStop <= 1'b1;
        for (int i = 0; i < memCtrlPkg::NUM_TFS; i++) begin
            expectLoad(32'h400 + 4 * i, 10'h100 + i);
            issueReq(memCtrlPkg::CMD_LOAD, 32'h400 + 4 * i, 10'h100 + i);
        end
        expectLoad(32'h440, 10'h1ff);
        driveReq(memCtrlPkg::CMD_LOAD, 32'h440, 10'h1ff);
        repeat (10) begin
            @(negedge clk);
            checkValue("stat.stall", 1, stat.stall);
        end
        @(posedge clk);
        arStop <= 1'b0;
        waitAccept();
        waitCompletions();
        checkValue("completions", accepted, completions());
        checkValue("pending loads", 0, expTag.size());
        endTest("backpressure", startErrs);

        // two write-backs in flight alongside the fills
        startErrs = errorCount;
        issueReq(memCtrlPkg::CMD_FILL, 32'h600, 10'h200);
        issueReq(memCtrlPkg::CMD_WRITEBACK, 32'h700, 10'h240);
        issueReq(memCtrlPkg::CMD_FILL, 32'h800, 10'h280);
        issueReq(memCtrlPkg::CMD_WRITEBACK, 32'h900, 10'h2c0);
        issueReq(memCtrlPkg::CMD_FILL, 32'ha00, 10'h300);
        waitCompletions();
        checkFillLine(32'h600, 10'h200);
        checkFillLine(32'h800, 10'h280);
        checkFillLine(32'ha00, 10'h300);
        checkWbLine(32'h700, 10'h240);
        checkWbLine(32'h900, 10'h2c0);
        checkValue("outstanding AW", 0, awIdSeen.size());
        endTest("mixed", startErrs);

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: memController.f
common/memCtrlPkg.sv
transferTable/transferTable.sv
transferTable/axiRequestIssue.sv
cacheIf/cacheFillWriter.sv
cacheIf/cacheLineReader.sv
hdl/memController.sv
verification/axiMemModel.sv
verification/memControllerTb.sv

// File: Bender.yml
package:
  name: memController

sources:
  - common/memCtrlPkg.sv
  - transferTable/transferTable.sv
  - transferTable/axiRequestIssue.sv
  - cacheIf/cacheFillWriter.sv
  - cacheIf/cacheLineReader.sv
  - hdl/memController.sv
  - target: test
    files:
      - verification/axiMemModel.sv
      - verification/memControllerTb.sv
